// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_dma
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
PASS_MSG  = ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== burst_mem_port.sv ====
`timescale 1ns/1ns

module burst_mem_port #(
	parameter int MEM_WORDS  = 1024,
	parameter int FIFO_DEPTH = 256
) (
	input  logic               clk,
	input  logic               reset_d,
	input  logic               cmd_en,
	input  dma_pkg::mem_cmd_t  cmd,
	input  logic               wr_en,
	input  dma_pkg::word_t     wr_data,
	input  logic               rd_en,
	output logic               cmd_full,
	output logic               wr_full,
	output dma_pkg::word_t     rd_data,
	output logic               rd_empty,
	output logic               mem_ready
);
	import dma_pkg::*;

	localparam int AW = $clog2(MEM_WORDS);

	typedef enum logic [1:0] {
		port_clear,
		port_idle,
		port_write,
		port_read
	} port_state_e;

	port_state_e   state;
	word_t         mem [MEM_WORDS];
	logic [AW-1:0] word_addr;
	logic [6:0]    words_left;
	logic [6:0]    pop_left;
	logic          wq_pop;
	logic          wq_valid;
	logic          wq_empty;
	word_t         wq_data;
	logic          rq_push;
	logic          rq_full;
	logic          mem_we;

	// Write data waits here until its command arrives
	stream_fifo #(.DEPTH(FIFO_DEPTH), .DWIDTH(32)) i_wr_queue (
		.clk       (clk),
		.reset_d   (reset_d),
		.push      (wr_en),
		.push_data (wr_data),
		.pop       (wq_pop),
		.pop_data  (wq_data),
		.pop_valid (wq_valid),
		.count     (),
		.full      (wr_full),
		.empty     (wq_empty)
	);

	stream_fifo #(.DEPTH(FIFO_DEPTH), .DWIDTH(32)) i_rd_queue (
		.clk       (clk),
		.reset_d   (reset_d),
		.push      (rq_push),
		.push_data (mem[word_addr]),
		.pop       (rd_en),
		.pop_data  (rd_data),
		.pop_valid (),
		.count     (),
		.full      (rq_full),
		.empty     (rd_empty)
	);

	// Busy through calibration and every burst
	assign cmd_full = (state != port_idle);
	assign wq_pop   = (state == port_write) && (pop_left != '0) && !wq_empty;
	assign rq_push  = (state == port_read) && !rq_full;
	assign mem_we   = (state == port_clear) || (state == port_write && wq_valid);

	always_ff @(posedge clk) begin
		if (mem_we)
			mem[word_addr] <= (state == port_clear) ? '0 : wq_data;
	end

	always_ff @(posedge clk or posedge reset_d) begin
		if (reset_d) begin
			state      <= port_clear;
			word_addr  <= '0;
			words_left <= '0;
			pop_left   <= '0;
			mem_ready  <= 1'b0;
		end else begin
			case (state)
				// Calibration stand-in, one word per cycle
				port_clear: begin
					word_addr <= word_addr + 1'b1;
					if (word_addr == AW'(MEM_WORDS - 1)) begin
						state     <= port_idle;
						mem_ready <= 1'b1;
					end
				end
				port_idle: begin
					if (cmd_en) begin
						word_addr  <= cmd.byte_addr[AW+1:2];
						words_left <= {1'b0, cmd.bl} + 7'd1;
						pop_left   <= {1'b0, cmd.bl} + 7'd1;
						state      <= (cmd.instr == instr_write) ? port_write : port_read;
					end
				end
				port_write: begin
					if (wq_pop)
						pop_left <= pop_left - 7'd1;
					if (wq_valid) begin
						word_addr  <= word_addr + 1'b1;
						words_left <= words_left - 7'd1;
						if (words_left == 7'd1)
							state <= port_idle;
					end
				end
				port_read: begin
					if (rq_push) begin
						word_addr  <= word_addr + 1'b1;
						words_left <= words_left - 7'd1;
						if (words_left == 7'd1)
							state <= port_idle;
					end
				end
				default: state <= port_idle;
			endcase
		end
	end

	// Whole burst must land inside the array
	a_cmd_in_range: assert property (
		@(posedge clk) disable iff (reset_d)
		cmd_en |-> (int'(cmd.byte_addr[29:2]) + int'(cmd.bl)) < MEM_WORDS
	);

endmodule

// ==== dma_ctrl.sv ====
`timescale 1ns/1ns

module dma_ctrl #(
	parameter int BLOB_BURST_LEN  = 32,
	parameter int BLOCK_BURST_LEN = 4,
	parameter int FIFO_DEPTH      = 256
) (
	input  logic                  clk,
	input  logic                  reset_d,
	input  dma_pkg::dma_cfg_t     cfg,
	input  logic                  mem_ready,
	input  dma_pkg::word_t        ib_data,
	input  logic                  ib_valid,
	input  dma_pkg::fifo_count_t  ib_count,
	input  dma_pkg::fifo_count_t  ob_count,
	input  logic                  cmd_full,
	input  logic                  wr_full,
	input  logic                  rd_empty,
	input  dma_pkg::word_t        rd_data,
	output logic                  ib_re,
	output logic                  ob_we,
	output dma_pkg::word_t        ob_data,
	output logic                  rd_en,
	output logic                  cmd_en,
	output dma_pkg::mem_cmd_t     cmd,
	output logic                  wr_en,
	output dma_pkg::word_t        wr_data,
	output dma_pkg::dma_status_t  status
);
	import dma_pkg::*;

	// Blob address step per burst, four bytes per word
	localparam int BLOB_BYTES = 4 * BLOB_BURST_LEN;

	dma_state_e state;
	dma_state_e next_state;
	logic [6:0] burst_cnt;
	logic       block_lat;
	logic       go_pending;
	byte_addr_t blob_wr_addr;
	byte_addr_t blob_rd_addr;
	burst_len_t cmd_bl;
	logic       wr_start;
	logic       rd_start;
	logic       wr_issue;
	logic       rd_issue;

	always_comb begin
		wr_start = mem_ready && cfg.write_mode && (cfg.block_mode ?
			(go_pending && ib_count >= fifo_count_t'(BLOCK_BURST_LEN)) :
			(ib_count >= fifo_count_t'(BLOB_BURST_LEN)));
		// Reads only when the output buffer can take the whole burst
		rd_start = mem_ready && cfg.read_mode && (cfg.block_mode ?
			(go_pending && ob_count <= fifo_count_t'(FIFO_DEPTH - BLOCK_BURST_LEN)) :
			(ob_count <= fifo_count_t'(FIFO_DEPTH - BLOB_BURST_LEN)));
		wr_issue = (state == wr_close) && (burst_cnt == '0) && !cmd_full;
		rd_issue = (state == rd_cmd) && !cmd_full;
		cmd_bl   = block_lat ? burst_len_t'(BLOCK_BURST_LEN - 1) :
			burst_len_t'(BLOB_BURST_LEN - 1);
	end

	always_comb begin
		next_state = state;
		case (state)
			// Writes win over reads
			idle: begin
				if (wr_start)
					next_state = wr_fetch;
				else if (rd_start)
					next_state = rd_cmd;
			end
			wr_fetch: if (!wr_full) next_state = wr_wait;
			wr_wait:  if (ib_valid) next_state = wr_close;
			wr_close: begin
				if (burst_cnt != '0)
					next_state = wr_fetch;
				else if (!cmd_full)
					next_state = idle;
			end
			rd_cmd:   if (!cmd_full) next_state = rd_wait;
			rd_wait:  if (!rd_empty) next_state = rd_move;
			rd_move:  next_state = rd_check;
			rd_check: next_state = (burst_cnt == 7'd1) ? idle : rd_wait;
			default:  next_state = idle;
		endcase
	end

	always_ff @(posedge clk or posedge reset_d) begin
		if (reset_d) begin
			state        <= idle;
			burst_cnt    <= '0;
			block_lat    <= 1'b0;
			go_pending   <= 1'b0;
			blob_wr_addr <= '0;
			blob_rd_addr <= '0;
			ib_re        <= 1'b0;
			wr_en        <= 1'b0;
			cmd_en       <= 1'b0;
			rd_en        <= 1'b0;
			ob_we        <= 1'b0;
		end else begin
			state  <= next_state;
			ib_re  <= 1'b0;
			wr_en  <= 1'b0;
			cmd_en <= 1'b0;
			rd_en  <= 1'b0;
			ob_we  <= 1'b0;

			// Go stays pending until a block burst picks it up
			if (cfg.block_go)
				go_pending <= 1'b1;
			else if (!cfg.block_mode || (state == idle && (wr_start || rd_start)))
				go_pending <= 1'b0;

			case (state)
				idle: begin
					block_lat <= cfg.block_mode;
					burst_cnt <= cfg.block_mode ? 7'(BLOCK_BURST_LEN) : 7'(BLOB_BURST_LEN);
				end
				wr_fetch: if (!wr_full) ib_re <= 1'b1;
				wr_wait: begin
					if (ib_valid) begin
						wr_en     <= 1'b1;
						burst_cnt <= burst_cnt - 7'd1;
					end
				end
				wr_close: begin
					if (wr_issue) begin
						cmd_en <= 1'b1;
						if (!block_lat)
							blob_wr_addr <= blob_wr_addr + byte_addr_t'(BLOB_BYTES);
					end
				end
				rd_cmd: begin
					if (rd_issue) begin
						cmd_en <= 1'b1;
						if (!block_lat)
							blob_rd_addr <= blob_rd_addr + byte_addr_t'(BLOB_BYTES);
					end
				end
				rd_wait: if (!rd_empty) rd_en <= 1'b1;
				rd_check: begin
					ob_we     <= 1'b1;
					burst_cnt <= burst_cnt - 7'd1;
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == wr_wait && ib_valid)
			wr_data <= ib_data;
		// Read queue word is valid one cycle after rd_en
		if (state == rd_check)
			ob_data <= rd_data;
		if (wr_issue) begin
			cmd.instr     <= instr_write;
			cmd.byte_addr <= block_lat ? cfg.start_addr : blob_wr_addr;
			cmd.bl        <= cmd_bl;
		end else if (rd_issue) begin
			cmd.instr     <= instr_read;
			cmd.byte_addr <= block_lat ? cfg.start_addr : blob_rd_addr;
			cmd.bl        <= cmd_bl;
		end
	end

	always_comb begin
		status.busy         = (state != idle);
		// Filled in at the top level
		status.mem_ready    = 1'b0;
		status.blob_wr_addr = blob_wr_addr;
		status.blob_rd_addr = blob_rd_addr;
	end

	a_cmd_not_full: assert property (
		@(posedge clk) disable iff (reset_d)
		cmd_en |-> !cmd_full
	);

	a_wr_not_full: assert property (
		@(posedge clk) disable iff (reset_d)
		wr_en |-> !wr_full
	);

endmodule

// ==== dma_pkg.sv ====
package dma_pkg;

	// Data and address widths
	typedef logic [31:0] word_t;
	typedef logic [29:0] byte_addr_t;
	// Occupancy up to a depth of 1024
	typedef logic [10:0] fifo_count_t;
	// Burst length minus one
	typedef logic [5:0]  burst_len_t;

	// Memory port command kinds
	typedef enum logic [2:0] {
		instr_write = 3'b000,
		instr_read  = 3'b001
	} mem_instr_e;

	// Controller states
	typedef enum logic [2:0] {
		idle,
		wr_fetch,
		wr_wait,
		wr_close,
		rd_cmd,
		rd_wait,
		rd_move,
		rd_check
	} dma_state_e;

	typedef struct packed {
		mem_instr_e instr;
		byte_addr_t byte_addr;
		burst_len_t bl;
	} mem_cmd_t;

	typedef struct packed {
		logic       write_mode;
		logic       read_mode;
		logic       block_mode;
		// One cycle per go write
		logic       block_go;
		byte_addr_t start_addr;
	} dma_cfg_t;

	typedef struct packed {
		logic       busy;
		logic       mem_ready;
		byte_addr_t blob_wr_addr;
		byte_addr_t blob_rd_addr;
	} dma_status_t;

	typedef struct packed {
		logic       cyc;
		logic       stb;
		logic       we;
		logic [3:0] adr;
		word_t      dat;
	} wb_req_t;

	// Register word offsets
	localparam logic [3:0] REG_CTRL    = 4'd0;
	localparam logic [3:0] REG_ADDR    = 4'd1;
	localparam logic [3:0] REG_STATUS  = 4'd2;
	localparam logic [3:0] REG_BLOB_WR = 4'd3;
	localparam logic [3:0] REG_BLOB_RD = 4'd4;

endpackage

// ==== dma_regs.sv ====
`timescale 1ns/1ns

module dma_regs (
	input  logic                 clk,
	input  logic                 reset_d,
	input  dma_pkg::wb_req_t     wb,
	input  dma_pkg::dma_status_t status,
	output logic                 wb_ack,
	output dma_pkg::word_t       wb_dat_o,
	output dma_pkg::dma_cfg_t    cfg
);
	import dma_pkg::*;

	logic wb_hit;

	// New classic cycle, ack drops between back-to-back accesses
	assign wb_hit = wb.cyc && wb.stb && !wb_ack;

	always_ff @(posedge clk or posedge reset_d) begin
		if (reset_d) begin
			wb_ack <= 1'b0;
			cfg    <= '0;
		end else begin
			wb_ack       <= wb_hit;
			cfg.block_go <= 1'b0;
			if (wb_hit && wb.we) begin
				case (wb.adr)
					REG_CTRL: begin
						cfg.write_mode <= wb.dat[0];
						cfg.read_mode  <= wb.dat[1];
						cfg.block_mode <= wb.dat[2];
						cfg.block_go   <= wb.dat[3];
					end
					REG_ADDR: cfg.start_addr <= wb.dat[29:0];
					default: ;
				endcase
			end
		end
	end

	// Read data lines up with ack
	always_ff @(posedge clk) begin
		if (wb_hit && !wb.we) begin
			case (wb.adr)
				// Go is a strobe and reads back as zero
				REG_CTRL:    wb_dat_o <= {29'd0, cfg.block_mode, cfg.read_mode, cfg.write_mode};
				REG_ADDR:    wb_dat_o <= {2'd0, cfg.start_addr};
				REG_STATUS:  wb_dat_o <= {30'd0, status.mem_ready, status.busy};
				REG_BLOB_WR: wb_dat_o <= {2'd0, status.blob_wr_addr};
				REG_BLOB_RD: wb_dat_o <= {2'd0, status.blob_rd_addr};
				default:     wb_dat_o <= '0;
			endcase
		end
	end

	// Single-cycle ack even when the master keeps stb up
	a_ack_single: assert property (
		@(posedge clk) disable iff (reset_d)
		(wb_ack && wb.stb) |=> !wb_ack
	);

endmodule

// ==== dma_top.sv ====
`timescale 1ns/1ns

module dma_top #(
	parameter int BLOB_BURST_LEN  = 32,
	parameter int BLOCK_BURST_LEN = 4,
	parameter int FIFO_DEPTH      = 256,
	parameter int MEM_WORDS       = 1024
) (
	input  logic             clk,
	input  logic             reset_d,
	input  dma_pkg::wb_req_t wb,
	input  dma_pkg::word_t   in_data,
	input  logic             in_valid,
	input  logic             out_ready,
	output logic             wb_ack,
	output dma_pkg::word_t   wb_dat_o,
	output logic             in_ready,
	output dma_pkg::word_t   out_data,
	output logic             out_valid
);
	import dma_pkg::*;

	dma_cfg_t    cfg;
	dma_status_t ctrl_status;
	dma_status_t status;
	mem_cmd_t    cmd;
	fifo_count_t ib_count;
	fifo_count_t ob_count;
	word_t       ib_data;
	word_t       ob_data;
	word_t       wr_data;
	word_t       rd_data;
	logic        ib_re;
	logic        ib_valid;
	logic        ib_full;
	logic        ob_we;
	logic        ob_empty;
	logic        cmd_en;
	logic        cmd_full;
	logic        wr_en;
	logic        wr_full;
	logic        rd_en;
	logic        rd_empty;
	logic        mem_ready;

	assign in_ready  = !ib_full;
	// Popped word shows on out_data one cycle after the handshake
	assign out_valid = !ob_empty;
	assign status    = '{busy: ctrl_status.busy, mem_ready: mem_ready,
		blob_wr_addr: ctrl_status.blob_wr_addr, blob_rd_addr: ctrl_status.blob_rd_addr};

	dma_regs i_regs (
		.clk      (clk),
		.reset_d  (reset_d),
		.wb       (wb),
		.status   (status),
		.wb_ack   (wb_ack),
		.wb_dat_o (wb_dat_o),
		.cfg      (cfg)
	);

	dma_ctrl #(
		.BLOB_BURST_LEN  (BLOB_BURST_LEN),
		.BLOCK_BURST_LEN (BLOCK_BURST_LEN),
		.FIFO_DEPTH      (FIFO_DEPTH)
	) i_ctrl (
		.clk       (clk),
		.reset_d   (reset_d),
		.cfg       (cfg),
		.mem_ready (mem_ready),
		.ib_data   (ib_data),
		.ib_valid  (ib_valid),
		.ib_count  (ib_count),
		.ob_count  (ob_count),
		.cmd_full  (cmd_full),
		.wr_full   (wr_full),
		.rd_empty  (rd_empty),
		.rd_data   (rd_data),
		.ib_re     (ib_re),
		.ob_we     (ob_we),
		.ob_data   (ob_data),
		.rd_en     (rd_en),
		.cmd_en    (cmd_en),
		.cmd       (cmd),
		.wr_en     (wr_en),
		.wr_data   (wr_data),
		.status    (ctrl_status)
	);

	// Input buffer
	stream_fifo #(.DEPTH(FIFO_DEPTH), .DWIDTH(32)) i_in_buf (
		.clk       (clk),
		.reset_d   (reset_d),
		.push      (in_valid && in_ready),
		.push_data (in_data),
		.pop       (ib_re),
		.pop_data  (ib_data),
		.pop_valid (ib_valid),
		.count     (ib_count),
		.full      (ib_full),
		.empty     ()
	);

	// Output buffer
	stream_fifo #(.DEPTH(FIFO_DEPTH), .DWIDTH(32)) i_out_buf (
		.clk       (clk),
		.reset_d   (reset_d),
		.push      (ob_we),
		.push_data (ob_data),
		.pop       (out_ready && out_valid),
		.pop_data  (out_data),
		.pop_valid (),
		.count     (ob_count),
		.full      (),
		.empty     (ob_empty)
	);

	burst_mem_port #(
		.MEM_WORDS  (MEM_WORDS),
		.FIFO_DEPTH (FIFO_DEPTH)
	) i_mem_port (
		.clk       (clk),
		.reset_d   (reset_d),
		.cmd_en    (cmd_en),
		.cmd       (cmd),
		.wr_en     (wr_en),
		.wr_data   (wr_data),
		.rd_en     (rd_en),
		.cmd_full  (cmd_full),
		.wr_full   (wr_full),
		.rd_data   (rd_data),
		.rd_empty  (rd_empty),
		.mem_ready (mem_ready)
	);

endmodule

// ==== stream_fifo.sv ====
`timescale 1ns/1ns

module stream_fifo #(
	parameter int DEPTH  = 256,
	parameter int DWIDTH = 32
) (
	input  logic                 clk,
	input  logic                 reset_d,
	input  logic                 push,
	input  logic [DWIDTH-1:0]    push_data,
	input  logic                 pop,
	output logic [DWIDTH-1:0]    pop_data,
	output logic                 pop_valid,
	output dma_pkg::fifo_count_t count,
	output logic                 full,
	output logic                 empty
);
	import dma_pkg::*;

	// Power-of-two depth, pointers wrap on their own
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [DWIDTH-1:0] mem [DEPTH];
	logic [AW-1:0]     wr_ptr;
	logic [AW-1:0]     rd_ptr;
	logic              do_push;
	logic              do_pop;

	assign full    = (count == fifo_count_t'(DEPTH));
	assign empty   = (count == '0);
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
		if (do_pop)
			pop_data <= mem[rd_ptr];
	end

	always_ff @(posedge clk or posedge reset_d) begin
		if (reset_d) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			pop_valid <= 1'b0;
		end else begin
			pop_valid <= do_pop;
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	a_no_overflow: assert property (
		@(posedge clk) disable iff (reset_d)
		!(push && full) && !(pop && empty)
	);

endmodule

// ==== tb_dma.sv ====
`timescale 1ns/1ns

module tb_dma;
	import dma_pkg::*;

	localparam int BLOB_BURST_LEN  = 32;
	localparam int BLOCK_BURST_LEN = 4;
	localparam int FIFO_DEPTH      = 256;
	localparam int MEM_WORDS       = 1024;
	localparam int MEM_AW          = $clog2(MEM_WORDS);
	localparam int SEED            = 82862;
	// Two blob bursts, one block, one more blob burst
	localparam int TOTAL_WORDS     = 2 * BLOB_BURST_LEN + BLOCK_BURST_LEN + BLOB_BURST_LEN;
	localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 200 + MEM_WORDS;

	typedef logic [MEM_AW-1:0] mem_idx_t;

	logic       clk;
	logic       reset_d;
	wb_req_t    wb;
	word_t      in_data;
	logic       in_valid;
	logic       out_ready = 1'b1;
	logic       wb_ack;
	word_t      wb_dat_o;
	logic       in_ready;
	word_t      out_data;
	logic       out_valid;

	word_t      ref_mem [MEM_WORDS];
	word_t      exp_q [$];
	byte_addr_t model_wr;
	byte_addr_t model_rd;
	logic       toggle_ready = 1'b0;
	logic       pop_seen = 1'b0;

	dma_top #(
		.BLOB_BURST_LEN  (BLOB_BURST_LEN),
		.BLOCK_BURST_LEN (BLOCK_BURST_LEN),
		.FIFO_DEPTH      (FIFO_DEPTH),
		.MEM_WORDS       (MEM_WORDS)
	) i_dut (
		.clk       (clk),
		.reset_d   (reset_d),
		.wb        (wb),
		.in_data   (in_data),
		.in_valid  (in_valid),
		.out_ready (out_ready),
		.wb_ack    (wb_ack),
		.wb_dat_o  (wb_dat_o),
		.in_ready  (in_ready),
		.out_data  (out_data),
		.out_valid (out_valid)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	task automatic compare_word(input string name, input word_t got, input word_t exp);
		if (got !== exp)
			abort_run($sformatf("FAIL %0t ns %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic compare_addr(input string name, input byte_addr_t got, input byte_addr_t exp);
		if (got !== exp)
			abort_run($sformatf("FAIL %0t ns %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic compare_status(input string name, input dma_status_t got,
		input dma_status_t exp);
		if (got !== exp)
			abort_run($sformatf(
				"FAIL %0t ns %s got busy=%0b ready=%0b wr=%h rd=%h expected busy=%0b ready=%0b wr=%h rd=%h",
				$time, name, got.busy, got.mem_ready, got.blob_wr_addr, got.blob_rd_addr,
				exp.busy, exp.mem_ready, exp.blob_wr_addr, exp.blob_rd_addr));
	endtask

	// Expected memory word at a byte address
	function automatic word_t expected_word(input byte_addr_t addr);
		return ref_mem[mem_idx_t'(addr >> 2)];
	endfunction

	// One classic cycle, ack comes back a cycle after stb
	task automatic wishbone_cycle(input logic we, input logic [3:0] adr, input word_t dat,
		output word_t rdata);
		int waited;
		@(negedge clk);
		wb.cyc = 1'b1;
		wb.stb = 1'b1;
		wb.we  = we;
		wb.adr = adr;
		wb.dat = dat;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
			if (waited > 16)
				abort_run("Wishbone ack did not arrive within 16 cycles");
		end while (!wb_ack);
		rdata = wb_dat_o;
		wb = '0;
	endtask

	task automatic write_reg(input logic [3:0] adr, input word_t dat);
		word_t unused;
		wishbone_cycle(1'b1, adr, dat, unused);
	endtask

	task automatic read_reg(input logic [3:0] adr, output word_t rdata);
		wishbone_cycle(1'b0, adr, '0, rdata);
	endtask

	task automatic read_status(output dma_status_t st);
		word_t r;
		read_reg(REG_STATUS, r);
		st.busy      = r[0];
		st.mem_ready = r[1];
		read_reg(REG_BLOB_WR, r);
		st.blob_wr_addr = r[29:0];
		read_reg(REG_BLOB_RD, r);
		st.blob_rd_addr = r[29:0];
	endtask

	// Idle must hold over a few reads, one idle cycle sits between bursts
	task automatic wait_idle();
		int    quiet;
		word_t r;
		quiet = 0;
		while (quiet < 3) begin
			read_reg(REG_STATUS, r);
			if (r[0])
				quiet = 0;
			else
				quiet++;
		end
	endtask

	task automatic wait_read_addr(input byte_addr_t target);
		word_t r;
		do
			read_reg(REG_BLOB_RD, r);
		while (byte_addr_t'(r[29:0]) < target);
	endtask

	// Valid only goes up when the buffer has room, so every word lands
	task automatic push_word(input word_t w);
		@(negedge clk);
		while (!in_ready) begin
			in_valid = 1'b0;
			@(negedge clk);
		end
		in_valid = 1'b1;
		in_data  = w;
	endtask

	task automatic send_blob(input int bursts);
		word_t w;
		for (int b = 0; b < bursts; b++) begin
			for (int k = 0; k < BLOB_BURST_LEN; k++) begin
				w = $urandom;
				ref_mem[mem_idx_t'((model_wr + byte_addr_t'(4 * k)) >> 2)] = w;
				push_word(w);
			end
			model_wr = model_wr + byte_addr_t'(4 * BLOB_BURST_LEN);
		end
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	task automatic load_block(input byte_addr_t addr);
		word_t w;
		for (int k = 0; k < BLOCK_BURST_LEN; k++) begin
			w = $urandom;
			ref_mem[mem_idx_t'((addr + byte_addr_t'(4 * k)) >> 2)] = w;
			push_word(w);
		end
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	task automatic expect_words(input byte_addr_t addr, input int n);
		for (int k = 0; k < n; k++)
			exp_q.push_back(expected_word(addr + byte_addr_t'(4 * k)));
	endtask

	task automatic expect_blob_read(input int bursts);
		for (int b = 0; b < bursts; b++) begin
			expect_words(model_rd, BLOB_BURST_LEN);
			model_rd = model_rd + byte_addr_t'(4 * BLOB_BURST_LEN);
		end
	endtask

	task automatic drain_output();
		while (exp_q.size() != 0)
			@(posedge clk);
	endtask

	task automatic check_out_empty();
		@(negedge clk);
		if (out_valid)
			abort_run("Output buffer still holds words after all expected ones arrived");
	endtask

	// Output consumer
	always @(negedge clk)
		out_ready <= toggle_ready ? 1'($urandom_range(0, 1)) : 1'b1;

	always @(posedge clk)
		pop_seen <= out_ready && out_valid;

	// Popped word is on out_data after the handshake edge
	always @(negedge clk) begin
		if (pop_seen) begin
			if (exp_q.size() == 0)
				abort_run("Output stream delivered a word that was not expected");
			else
				compare_word("out_data", out_data, exp_q.pop_front());
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		abort_run($sformatf("Timeout, the run did not finish in %0d cycles", WATCHDOG_CYCLES));
	end

	initial begin
		dma_status_t st;
		dma_status_t exp_st;
		word_t       r;
		word_t       d;
		byte_addr_t  blk_addr;

		void'($urandom(SEED));
		reset_d  = 1'b1;
		wb       = '0;
		in_valid = 1'b0;
		in_data  = '0;
		model_wr = '0;
		model_rd = '0;
		foreach (ref_mem[i])
			ref_mem[i] = '0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset_d = 1'b0;

		// Reset state once the array is cleared
		do
			read_reg(REG_STATUS, r);
		while (!r[1]);
		read_status(st);
		exp_st = '{busy: 1'b0, mem_ready: 1'b1, blob_wr_addr: '0, blob_rd_addr: '0};
		compare_status("status", st, exp_st);

		// Blob write of two bursts
		write_reg(REG_CTRL, 32'h1);
		send_blob(2);
		wait_idle();
		read_reg(REG_BLOB_WR, r);
		compare_addr("blob_wr_addr", r[29:0], model_wr);

		// Blob read-back, stopped after the second burst
		write_reg(REG_CTRL, 32'h0);
		expect_blob_read(2);
		write_reg(REG_CTRL, 32'h2);
		wait_read_addr(model_rd);
		write_reg(REG_CTRL, 32'h0);
		drain_output();
		wait_idle();
		check_out_empty();
		read_reg(REG_BLOB_RD, r);
		compare_addr("blob_rd_addr", r[29:0], model_rd);

		// Block write then block read at a random aligned address
		blk_addr = byte_addr_t'($urandom_range(128, 254) * 16);
		write_reg(REG_ADDR, {2'b00, blk_addr});
		load_block(blk_addr);
		write_reg(REG_CTRL, 32'hD);
		wait_idle();
		expect_words(blk_addr, BLOCK_BURST_LEN);
		write_reg(REG_CTRL, 32'hE);
		drain_output();
		write_reg(REG_CTRL, 32'h0);
		wait_idle();
		check_out_empty();
		read_status(st);
		exp_st = '{busy: 1'b0, mem_ready: 1'b1, blob_wr_addr: model_wr, blob_rd_addr: model_rd};
		compare_status("status", st, exp_st);

		// One more burst, read back under random back-pressure
		write_reg(REG_CTRL, 32'h1);
		send_blob(1);
		wait_idle();
		read_reg(REG_BLOB_WR, r);
		compare_addr("blob_wr_addr", r[29:0], model_wr);
		write_reg(REG_CTRL, 32'h0);
		toggle_ready = 1'b1;
		expect_blob_read(1);
		write_reg(REG_CTRL, 32'h2);
		wait_read_addr(model_rd);
		write_reg(REG_CTRL, 32'h0);
		drain_output();
		wait_idle();
		toggle_ready = 1'b0;
		check_out_empty();
		read_reg(REG_BLOB_RD, r);
		compare_addr("blob_rd_addr", r[29:0], model_rd);

		// Register readback, read enable kept off so nothing moves
		for (int i = 0; i < 16; i++) begin
			d = $urandom & ~32'h2;
			write_reg(REG_CTRL, d);
			read_reg(REG_CTRL, r);
			compare_word("ctrl", r, d & 32'h5);
			d = $urandom;
			write_reg(REG_ADDR, d);
			read_reg(REG_ADDR, r);
			compare_word("addr", r, d & 32'h3FFF_FFFF);
		end
		write_reg(REG_CTRL, 32'h0);

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

// ==== verilog.f ====
dma_pkg.sv
stream_fifo.sv
dma_regs.sv
dma_ctrl.sv
burst_mem_port.sv
dma_top.sv
tb_dma.sv
